// ==== source/song_rom.svh ====
/*
 * Built-in song table, included inside the song reader and the testbench.
 * Positions past the listed entries read as the end marker.
 * A song that fills all positions ends after its last entry.
 */

// Look up one table entry for a song and a position within it
function automatic music_pkg::note_t song_entry(
    input logic [music_pkg::SONG_W-1:0] song,
    input logic [music_pkg::POS_W-1:0] pos
);
    music_pkg::note_t e;
    e = '{note: 6'd0, duration: 6'd0};
    case ({song, pos})
        // Song 0, a rising line with one rest
        {2'd0, 4'd0}: e = '{note: 6'd49, duration: 6'd4};
        {2'd0, 4'd1}: e = '{note: 6'd51, duration: 6'd2};
        {2'd0, 4'd2}: e = '{note: 6'd53, duration: 6'd2};
        {2'd0, 4'd3}: e = '{note: 6'd0, duration: 6'd1};
        {2'd0, 4'd4}: e = '{note: 6'd54, duration: 6'd4};
        {2'd0, 4'd5}: e = '{note: 6'd56, duration: 6'd2};
        {2'd0, 4'd6}: e = '{note: 6'd58, duration: 6'd2};
        {2'd0, 4'd7}: e = '{note: 6'd61, duration: 6'd6};
        // Song 1
        {2'd1, 4'd0}: e = '{note: 6'd44, duration: 6'd3};
        {2'd1, 4'd1}: e = '{note: 6'd47, duration: 6'd3};
        {2'd1, 4'd2}: e = '{note: 6'd44, duration: 6'd2};
        {2'd1, 4'd3}: e = '{note: 6'd40, duration: 6'd2};
        {2'd1, 4'd4}: e = '{note: 6'd0, duration: 6'd2};
        {2'd1, 4'd5}: e = '{note: 6'd42, duration: 6'd5};
        // Song 2
        {2'd2, 4'd0}: e = '{note: 6'd56, duration: 6'd2};
        {2'd2, 4'd1}: e = '{note: 6'd54, duration: 6'd2};
        {2'd2, 4'd2}: e = '{note: 6'd52, duration: 6'd2};
        {2'd2, 4'd3}: e = '{note: 6'd51, duration: 6'd2};
        {2'd2, 4'd4}: e = '{note: 6'd49, duration: 6'd8};
        // Song 3, short
        {2'd3, 4'd0}: e = '{note: 6'd37, duration: 6'd4};
        {2'd3, 4'd1}: e = '{note: 6'd41, duration: 6'd4};
        {2'd3, 4'd2}: e = '{note: 6'd44, duration: 6'd4};
        {2'd3, 4'd3}: e = '{note: 6'd49, duration: 6'd8};
        default: e = '{note: 6'd0, duration: 6'd0};
    endcase
    return e;
endfunction

// ==== source/music_pkg.sv ====
/*
 * Shared types and constants for the single-voice tone player.
 * Pitches assume a 48 kHz sample rate and use the lowest octave table shifted per octave.
 * Note 0 is a rest and a duration of 0 marks the end of a song.
 */
`default_nettype none

package music_pkg;

    localparam int NUM_SONGS = 4;
    localparam int SONG_LEN = 16;
    localparam int SONG_W = $clog2(NUM_SONGS);
    localparam int POS_W = $clog2(SONG_LEN);

    // Peak value of the square wave, well under full scale
    localparam logic signed [15:0] AMPLITUDE = 16'sd4096;

    // One song table entry, pitch in the upper half and length in beats below
    typedef struct packed {
        logic [5:0] note;
        logic [5:0] duration;
    } note_t;

    typedef enum logic [1:0] {
        paused,
        playing,
        next_song
    } mcu_state_t;

    // Half period in samples, each octave up halves the lowest octave count
    function automatic logic [15:0] half_period(input logic [5:0] note);
        logic [5:0] idx;
        logic [2:0] octave;
        logic [3:0] semi;
        logic [15:0] base;
        logic [15:0] hp;
        idx = note - 6'd1;
        octave = 3'(idx / 6'd12);
        semi = 4'(idx % 6'd12);
        case (semi)
            4'd0: base = 16'd873;
            4'd1: base = 16'd824;
            4'd2: base = 16'd778;
            4'd3: base = 16'd734;
            4'd4: base = 16'd693;
            4'd5: base = 16'd654;
            4'd6: base = 16'd617;
            4'd7: base = 16'd583;
            4'd8: base = 16'd550;
            4'd9: base = 16'd519;
            4'd10: base = 16'd490;
            default: base = 16'd462;
        endcase
        hp = base >> octave;
        // A rest has no pitch, so any legal count will do
        if (note == 6'd0 || hp < 16'd2) begin
            hp = 16'd2;
        end
        return hp;
    endfunction

endpackage

`default_nettype wire

// ==== source/mcu.sv ====
/*
 * Play control state machine.
 * Buttons are single-cycle strobes and act one cycle later.
 * Buttons arriving during the one-cycle song change are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module mcu (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             play_button,
    input  logic                             next_button,
    input  logic                             song_done,
    output logic                             play,
    output logic                             reset_player,
    output logic [music_pkg::SONG_W-1:0]     song
);

    music_pkg::mcu_state_t state;
    music_pkg::mcu_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            music_pkg::paused: begin
                // Moving on to another song wins over a play press
                if (next_button || song_done) begin
                    state_next = music_pkg::next_song;
                end else if (play_button) begin
                    state_next = music_pkg::playing;
                end
            end
            music_pkg::playing: begin
                if (next_button || song_done) begin
                    state_next = music_pkg::next_song;
                end else if (play_button) begin
                    state_next = music_pkg::paused;
                end
            end
            // Single cycle stop, the song reader is cleared here
            music_pkg::next_song: state_next = music_pkg::paused;
            default: state_next = music_pkg::paused;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= music_pkg::paused;
            song <= '0;
        end else begin
            state <= state_next;
            // The song index moves on entry so it is stable once reset_player drops
            if (state_next == music_pkg::next_song && state != music_pkg::next_song) begin
                if (song == music_pkg::SONG_W'(music_pkg::NUM_SONGS - 1)) begin
                    song <= '0;
                end else begin
                    song <= song + 1'b1;
                end
            end
        end
    end

    assign play = (state == music_pkg::playing);
    assign reset_player = (state == music_pkg::next_song);

endmodule

`default_nettype wire

// ==== source/song_reader.sv ====
/*
 * Steps through one song of the table and hands out one note at a time.
 * Expects to be reset whenever the song index changes.
 * After the song ends it stays idle until the next reset.
 */
`timescale 1ns/1ps
`default_nettype none

module song_reader (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             play,
    input  logic [music_pkg::SONG_W-1:0]     song,
    output music_pkg::note_t                 next_note,
    output logic                             new_note,
    input  logic                             note_done,
    output logic                             song_done
);

    `include "song_rom.svh"

    logic [music_pkg::POS_W-1:0] pos;
    // A note has been handed out and its note_done has not come back yet
    logic pending;
    // The last table position has been issued
    logic at_end;
    // The song has finished, hold off until reset
    logic song_over;
    music_pkg::note_t entry;
    logic end_of_song;
    logic note_finished;
    logic issue;

    always_comb begin
        entry = song_entry(song, pos);
        end_of_song = at_end || (entry.duration == 6'd0);
        // A done arriving next to a fresh note belongs to the note it replaced
        // It can only come from the player's old note right after a resume
        note_finished = note_done && !new_note;
        issue = play && !song_over && (!pending || note_finished);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
            pending <= 1'b0;
            at_end <= 1'b0;
            song_over <= 1'b0;
            new_note <= 1'b0;
            song_done <= 1'b0;
        end else begin
            new_note <= 1'b0;
            song_done <= 1'b0;
            if (issue) begin
                if (end_of_song) begin
                    // No note for the marker, only the done strobe to the controller
                    song_done <= 1'b1;
                    song_over <= 1'b1;
                    pending <= 1'b0;
                end else begin
                    new_note <= 1'b1;
                    pending <= 1'b1;
                    pos <= pos + 1'b1;
                    at_end <= (pos == music_pkg::POS_W'(music_pkg::SONG_LEN - 1));
                end
            end else if (note_finished) begin
                // Paused when the note ran out, the next one goes on resume
                pending <= 1'b0;
            end
        end
    end

    // The note record is payload and is only read with new_note
    always_ff @(posedge clk) begin
        if (issue && !end_of_song) begin
            next_note <= entry;
        end
    end

endmodule

`default_nettype wire

// ==== source/note_player.sv ====
/*
 * Square-wave voice with a beat-counted note timer.
 * Playback speed divides note lengths by 1, 2, 4 or 8, never below one beat.
 * The output is silent for rests, while paused and once a note has run out.
 */
`timescale 1ns/1ps
`default_nettype none

module note_player (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     play_enable,
    input  music_pkg::note_t         next_note,
    input  logic                     load_new_note,
    input  logic                     playback,
    input  logic                     beat,
    input  logic                     generate_next_sample,
    output logic                     note_done,
    output logic signed [15:0]       note_sample,
    output logic                     new_sample_ready
);

    logic [1:0] speed;
    logic [5:0] cur_note;
    logic loaded;
    logic [5:0] timer;
    logic [5:0] scaled;
    // Low while in the positive half of the wave
    logic sign;
    logic [15:0] half_cnt;
    logic [15:0] hp;
    logic active;

    always_comb begin
        scaled = next_note.duration >> speed;
        hp = music_pkg::half_period(cur_note);
        active = loaded && play_enable && (cur_note != 6'd0);
    end

    // Speed steps on each playback press and wraps back to normal
    always_ff @(posedge clk) begin
        if (reset) begin
            speed <= 2'd0;
        end else if (playback) begin
            speed <= speed + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= 1'b0;
            timer <= '0;
            note_done <= 1'b0;
        end else begin
            note_done <= 1'b0;
            if (load_new_note) begin
                loaded <= 1'b1;
                timer <= (scaled == 6'd0) ? 6'd1 : scaled;
            end else if (play_enable && beat && loaded) begin
                if (timer == 6'd1) begin
                    loaded <= 1'b0;
                    note_done <= 1'b1;
                end
                timer <= timer - 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_new_note) begin
            cur_note <= next_note.note;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sign <= 1'b0;
            half_cnt <= '0;
            new_sample_ready <= 1'b0;
        end else begin
            new_sample_ready <= generate_next_sample;
            if (load_new_note) begin
                // Every note starts on the positive half
                sign <= 1'b0;
                half_cnt <= '0;
            end else if (generate_next_sample && active) begin
                if (half_cnt >= hp - 16'd1) begin
                    half_cnt <= '0;
                    sign <= ~sign;
                end else begin
                    half_cnt <= half_cnt + 16'd1;
                end
            end
        end
    end

    // Sample taken from the current half before the counter moves on
    always_ff @(posedge clk) begin
        if (generate_next_sample) begin
            if (!active) begin
                note_sample <= '0;
            end else if (sign) begin
                note_sample <= -music_pkg::AMPLITUDE;
            end else begin
                note_sample <= music_pkg::AMPLITUDE;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/beat_generator.sv ====
/*
 * Divides the sample request strobe down to a beat strobe.
 * One beat for every BEAT_COUNT enables, the beat lags the enable by one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module beat_generator #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    output logic beat
);

    // Counter wide enough for BEAT_COUNT-1, at least one bit
    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            beat <= 1'b0;
        end else begin
            beat <= 1'b0;
            if (en) begin
                if (count == CNT_W'(BEAT_COUNT - 1)) begin
                    count <= '0;
                    beat <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/codec_conditioner.sv ====
/*
 * Lines samples up with the codec frame strobe.
 * A sample computed between frames is held and goes out on the next frame.
 * Frames must come at least 4 cycles apart so a sample is ready in time.
 */
`timescale 1ns/1ps
`default_nettype none

module codec_conditioner (
    input  logic                 clk,
    input  logic                 reset,
    input  logic signed [15:0]   new_sample_in,
    input  logic                 latch_new_sample_in,
    input  logic                 new_frame,
    output logic                 generate_next_sample,
    output logic signed [15:0]   valid_sample
);

    // Sample waiting for the next frame
    logic signed [15:0] pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            valid_sample <= '0;
            generate_next_sample <= 1'b0;
        end else begin
            if (latch_new_sample_in) begin
                pending <= new_sample_in;
            end
            // Output and request move together, one cycle after the frame
            generate_next_sample <= new_frame;
            if (new_frame) begin
                valid_sample <= pending;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/music_player.sv ====
/*
 * Single-voice music player, top level.
 * Button inputs must already be debounced single-cycle strobes.
 * BEAT_COUNT sets samples per beat, lower it to shorten simulation.
 */
`timescale 1ns/1ps
`default_nettype none

module music_player #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 play_button,
    input  logic                 next_button,
    input  logic                 playback,
    input  logic                 new_frame,
    output logic                 new_sample_generated,
    output logic signed [15:0]   sample_out
);

    logic play;
    logic reset_player;
    logic [music_pkg::SONG_W-1:0] song;
    logic song_done;
    music_pkg::note_t next_note;
    logic new_note;
    logic note_done;
    logic beat;
    logic generate_next_sample;
    logic signed [15:0] note_sample;
    logic new_sample_ready;

    mcu mcu0 (
        .clk          (clk),
        .reset        (reset),
        .play_button  (play_button),
        .next_button  (next_button),
        .song_done    (song_done),
        .play         (play),
        .reset_player (reset_player),
        .song         (song)
    );

    // Only the reader restarts on a song change, the voice keeps its state
    song_reader song_reader0 (
        .clk       (clk),
        .reset     (reset | reset_player),
        .play      (play),
        .song      (song),
        .next_note (next_note),
        .new_note  (new_note),
        .note_done (note_done),
        .song_done (song_done)
    );

    note_player note_player0 (
        .clk                  (clk),
        .reset                (reset),
        .play_enable          (play),
        .next_note            (next_note),
        .load_new_note        (new_note),
        .playback             (playback),
        .beat                 (beat),
        .generate_next_sample (generate_next_sample),
        .note_done            (note_done),
        .note_sample          (note_sample),
        .new_sample_ready     (new_sample_ready)
    );

    // Beats are counted in sample requests, so they follow the codec rate
    beat_generator #(
        .BEAT_COUNT (BEAT_COUNT)
    ) beat_generator0 (
        .clk   (clk),
        .reset (reset),
        .en    (generate_next_sample),
        .beat  (beat)
    );

    codec_conditioner codec_conditioner0 (
        .clk                  (clk),
        .reset                (reset),
        .new_sample_in        (note_sample),
        .latch_new_sample_in  (new_sample_ready),
        .new_frame            (new_frame),
        .generate_next_sample (generate_next_sample),
        .valid_sample         (sample_out)
    );

    assign new_sample_generated = generate_next_sample;

endmodule

`default_nettype wire

// ==== testbench/music_player_tb.sv ====
/*
 * Testbench for the single-voice music player.
 * Frames come every 6 cycles and BEAT_COUNT is large enough that a first note outlasts six half periods.
 * Pitch and song length are predicted from the song table and the half period rule.
 */
`timescale 1ns/1ps
`default_nettype none

module music_player_tb;

    `include "song_rom.svh"

    // Beats long enough that the first notes of songs 0 and 1 show six sign flips
    localparam int BEAT_COUNT = 256;
    localparam int FRAME_GAP = 6;
    localparam int FRAME_TIMEOUT = 4 * FRAME_GAP;
    localparam int START_FRAMES = 10;
    localparam int BTN_PLAY = 0;
    localparam int BTN_NEXT = 1;
    localparam int BTN_SPEED = 2;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic play_button = 1'b0;
    logic next_button = 1'b0;
    logic playback = 1'b0;
    logic new_frame = 1'b0;
    logic new_sample_generated;
    logic signed [15:0] sample_out;

    // Copies of the previous cycle for the frame checks
    logic frame_q = 1'b0;
    logic signed [15:0] sample_q = '0;
    int frame_cnt = 0;
    int errors = 0;
    int timeouts = 0;

    music_player #(
        .BEAT_COUNT (BEAT_COUNT)
    ) dut0 (
        .clk                  (clk),
        .reset                (reset),
        .play_button          (play_button),
        .next_button          (next_button),
        .playback             (playback),
        .new_frame            (new_frame),
        .new_sample_generated (new_sample_generated),
        .sample_out           (sample_out)
    );

    initial begin
        forever begin
            #2;
            clk = ~clk;
        end
    end

    // Codec frame strobe that is high for one cycle in every FRAME_GAP
    always @(posedge clk) begin
        if (reset) begin
            frame_cnt <= 0;
            new_frame <= 1'b0;
        end else begin
            frame_cnt <= (frame_cnt == FRAME_GAP - 1) ? 0 : frame_cnt + 1;
            new_frame <= (frame_cnt == FRAME_GAP - 1);
        end
    end

    always @(posedge clk) begin
        frame_q <= new_frame;
        sample_q <= sample_out;
    end

    // A sample request follows each frame by exactly one cycle
    assert property (@(posedge clk) disable iff (reset) new_sample_generated == frame_q)
    else begin
        errors++;
        $display("[FAIL] %0t new_sample_generated: expected %0b, got %0b",
                 $time, $sampled(frame_q), $sampled(new_sample_generated));
    end

    // The output may only move together with a sample request
    assert property (@(posedge clk) disable iff (reset)
                     (sample_out != sample_q) |-> new_sample_generated)
    else begin
        errors++;
        $display("[FAIL] %0t sample_out: expected %0d, got %0d",
                 $time, $sampled(sample_q), $sampled(sample_out));
    end

    assert property (@(posedge clk) disable iff (reset)
                     sample_out == 16'sd0 || sample_out == music_pkg::AMPLITUDE
                     || sample_out == -music_pkg::AMPLITUDE)
    else begin
        errors++;
        $display("[FAIL] %0t sample_out: expected 0 or +/-%0d, got %0d",
                 $time, music_pkg::AMPLITUDE, $sampled(sample_out));
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else begin
            errors++;
            $display("[FAIL] %0t %s: expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    // Returns the sample of the next frame as read mid-cycle while the request is high
    task automatic wait_frame(output logic signed [15:0] s);
        int n;
        logic got;
        s = '0;
        got = 1'b0;
        n = 0;
        if (timeouts == 0) begin
            while (!got && n < FRAME_TIMEOUT) begin
                @(negedge clk);
                n++;
                if (new_sample_generated) begin
                    got = 1'b1;
                    s = sample_out;
                end
            end
            if (!got) begin
                timeouts++;
                $display("%0t: no sample request within %0d cycles", $time, FRAME_TIMEOUT);
            end
        end
    endtask

    task automatic press_button(input int which);
        @(posedge clk);
        case (which)
            BTN_PLAY: play_button <= 1'b1;
            BTN_NEXT: next_button <= 1'b1;
            default: playback <= 1'b1;
        endcase
        @(posedge clk);
        play_button <= 1'b0;
        next_button <= 1'b0;
        playback <= 1'b0;
    endtask

    // Pressing right after a request keeps the next request clear of the note load
    task automatic press_after_sample(input int which);
        logic signed [15:0] s;
        wait_frame(s);
        press_button(which);
    endtask

    // Each half of the wave lasts hp frames and the first half is positive
    task automatic check_flips(input int hp, input int flips);
        logic signed [15:0] s;
        logic signed [15:0] cur;
        int run;
        int seen;
        int n;
        s = '0;
        n = 0;
        while (s == 16'sd0 && n < START_FRAMES && timeouts == 0) begin
            wait_frame(s);
            n++;
        end
        check_value("sample_out", int'(s), int'(music_pkg::AMPLITUDE));
        cur = s;
        run = 1;
        seen = 0;
        n = 0;
        while (seen < flips && n < (flips + 1) * hp + 8 && timeouts == 0) begin
            wait_frame(s);
            n++;
            if (s == cur) begin
                run++;
            end else begin
                check_value("half period in frames", run, hp);
                check_value("sample_out", int'(s), -int'(cur));
                cur = s;
                run = 1;
                seen++;
            end
        end
        if (seen < flips) begin
            errors++;
            $display("%0t: only %0d of %0d sign flips were seen", $time, seen, flips);
        end
    endtask

    // Beats a song lasts at a given speed with each note at least one beat
    function automatic int song_beats(input logic [music_pkg::SONG_W-1:0] song, input int speed);
        music_pkg::note_t e;
        int total;
        int b;
        int p;
        logic ended;
        total = 0;
        ended = 1'b0;
        for (p = 0; p < music_pkg::SONG_LEN; p++) begin
            e = song_entry(song, music_pkg::POS_W'(p));
            if (e.duration == 6'd0) begin
                ended = 1'b1;
            end
            if (!ended) begin
                b = int'(e.duration) >> speed;
                total += (b == 0) ? 1 : b;
            end
        end
        return total;
    endfunction

    initial begin
        logic signed [15:0] s;
        music_pkg::note_t e;
        int n;
        int lo;
        int hi;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Silent until the first play press
        for (n = 0; n < 50; n++) begin
            wait_frame(s);
            check_value("sample_out", int'(s), 0);
        end

        press_after_sample(BTN_PLAY);
        e = song_entry(2'd0, 4'd0);
        check_flips(int'(music_pkg::half_period(e.note)), 6);

        // On pause the held sample drains within a couple of frames
        press_after_sample(BTN_PLAY);
        s = 16'sd1;
        n = 0;
        while (s != 16'sd0 && n < 3) begin
            wait_frame(s);
            n++;
        end
        check_value("sample_out", int'(s), 0);
        for (n = 0; n < 30; n++) begin
            wait_frame(s);
            check_value("sample_out", int'(s), 0);
        end

        // Song 1 from its start
        press_button(BTN_NEXT);
        press_after_sample(BTN_PLAY);
        e = song_entry(2'd1, 4'd0);
        check_flips(int'(music_pkg::half_period(e.note)), 6);

        // Song 2 at speed 2 runs to its end marker and the controller pauses
        press_after_sample(BTN_PLAY);
        press_button(BTN_NEXT);
        press_button(BTN_SPEED);
        press_button(BTN_SPEED);
        lo = (song_beats(2'd2, 2) - 1) * BEAT_COUNT;
        hi = (song_beats(2'd2, 2) + 1) * BEAT_COUNT + 8;
        press_after_sample(BTN_PLAY);
        s = '0;
        n = 0;
        while (s == 16'sd0 && n < START_FRAMES) begin
            wait_frame(s);
            n++;
        end
        n = 0;
        while (s != 16'sd0 && n <= hi) begin
            n++;
            wait_frame(s);
        end
        assert (n >= lo && n <= hi)
        else begin
            errors++;
            $display("[FAIL] %0t song length in frames: expected %0d to %0d, got %0d",
                     $time, lo, hi, n);
        end
        for (n = 0; n < 30; n++) begin
            wait_frame(s);
            check_value("sample_out", int'(s), 0);
        end

        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/music_pkg.sv
source/mcu.sv
source/song_reader.sv
source/note_player.sv
source/beat_generator.sv
source/codec_conditioner.sv
source/music_player.sv
testbench/music_player_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module music_player_tb -o sim_music_player

./obj_dir/sim_music_player | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
